/* tb.f */
+incdir+source
source/prefix_data_pkg.sv
source/prefix_ctrl_pkg.sv
source/pipe_control.sv
source/prefix_layer.sv
source/prefix_network.sv
source/prefix_adder_top.sv
verification/prefix_adder_assertions.sv
verification/prefix_adder_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the prefix adder testbench with Verilator
# a failed build or run also marks the log as failed

cd "$(dirname "$0")" || exit 1

log_file=sim.log
build_dir=obj_dir

rm -rf "$build_dir" "$log_file"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module prefix_adder_tb -f tb.f -Mdir "$build_dir" -o prefix_adder_sim \
	> "$log_file" 2>&1 \
	&& "./$build_dir/prefix_adder_sim" >> "$log_file" 2>&1 \
	|| echo "TEST FAILED" >> "$log_file"

cat "$log_file"

grep -q "TEST FAILED" "$log_file" \
	&& { echo "simulation failed, see $log_file"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

/* verification/prefix_adder_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "prefix_cfg.svh"

module prefix_adder_tb;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 1;
	localparam int PIPE_LATENCY = `PREFIX_STAGES;
	localparam int BURST_BLOCKS = 64;
	localparam int STALL_BLOCKS = 96;
	localparam int PLANNED_BLOCKS = 1 + BURST_BLOCKS + STALL_BLOCKS;
	localparam int CYCLES_PER_BLOCK = 20;

	logic clk;
	logic reset;
	logic valid_in;
	logic ready_in;
	prefix_ctrl_pkg::tag_t tag_in;
	prefix_data_pkg::block_t data_in;
	logic busy;
	logic ready_out;
	logic valid_out;
	prefix_ctrl_pkg::tag_t tag_out;
	prefix_data_pkg::block_t data_out;

	logic [31:0] lfsr_state;

	// blocks in flight, oldest first
	prefix_ctrl_pkg::tag_t tag_q [$];
	prefix_data_pkg::block_t block_q [$];
	int edge_q [$];

	int enabled_edges = 0;
	int accepted = 0;
	int delivered = 0;

	// outputs seen at the previous falling edge
	logic prev_stalled = 1'b0;
	logic prev_valid_out;
	prefix_ctrl_pkg::tag_t prev_tag_out;
	prefix_data_pkg::block_t prev_data_out;

	prefix_adder_top uut (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.ready_in(ready_in),
		.tag_in(tag_in),
		.data_in(data_in),
		.busy(busy),
		.ready_out(ready_out),
		.valid_out(valid_out),
		.tag_out(tag_out),
		.data_out(data_out)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// one step per bit taken
	task automatic take_bits(input int count, output logic [31:0] bits);
		bits = '0;
		for (int n = 0; n < count; n++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
	endtask

	// running sum over the lanes, wrapping at lane width
	function automatic prefix_data_pkg::block_t prefix_sums(input prefix_data_pkg::block_t blk);
		prefix_data_pkg::block_t result;
		prefix_data_pkg::lane_t running;
		running = '0;
		for (int i = 0; i < `PREFIX_LANES; i++) begin
			running = running + blk[i];
			result[i] = running;
		end
		return result;
	endfunction

	task automatic random_block();
		logic [31:0] bits;
		take_bits(`PREFIX_TAG_WIDTH, bits);
		tag_in = bits;
		for (int i = 0; i < `PREFIX_LANES; i++) begin
			take_bits(`PREFIX_LANE_WIDTH, bits);
			data_in[i] = bits[`PREFIX_LANE_WIDTH-1:0];
		end
	endtask

	task automatic report_mismatch(input string name, input string got, input string expected);
		$display("ERROR at %0t: %s is %s, expected %s", $time, name, got, expected);
		$display("TEST FAILED");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic report_failure(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("TEST FAILED");
		$fatal(1, "%s", what);
	endtask

	// needs ready_in high to make progress
	task automatic wait_for_drain();
		do begin
			@(posedge clk);
			#(DRIVE_DELAY);
		end while (tag_q.size() != 0 || busy);
	endtask

	// model and checks at the falling edge, where inputs and outputs are settled
	always @(negedge clk) begin
		prefix_data_pkg::block_t expected;
		if (reset) begin
			enabled_edges = 0;
			prev_stalled = 1'b0;
		end else begin
			assert (ready_out == ready_in)
				else report_mismatch("ready_out", $sformatf("%b", ready_out),
					$sformatf("%b", ready_in));
			assert (busy == (tag_q.size() != 0))
				else report_mismatch("busy", $sformatf("%b", busy),
					$sformatf("%b", tag_q.size() != 0));

			// nothing may move across a stalled edge
			if (prev_stalled) begin
				assert (valid_out == prev_valid_out)
					else report_mismatch("valid_out", $sformatf("%b", valid_out),
						$sformatf("%b", prev_valid_out));
				assert (tag_out == prev_tag_out)
					else report_mismatch("tag_out", $sformatf("%h", tag_out),
						$sformatf("%h", prev_tag_out));
				assert (data_out == prev_data_out)
					else report_mismatch("data_out", $sformatf("%h", data_out),
						$sformatf("%h", prev_data_out));
			end

			if (valid_out && ready_in) begin
				assert (tag_q.size() != 0)
					else report_failure("valid_out was high with no block in flight");
				expected = prefix_sums(block_q[0]);
				assert (tag_out == tag_q[0])
					else report_mismatch("tag_out", $sformatf("%h", tag_out),
						$sformatf("%h", tag_q[0]));
				for (int i = 0; i < `PREFIX_LANES; i++) begin
					assert (data_out[i] == expected[i])
						else report_mismatch($sformatf("data_out lane %0d", i),
							$sformatf("%h", data_out[i]), $sformatf("%h", expected[i]));
				end
				assert (enabled_edges - edge_q[0] == PIPE_LATENCY)
					else report_failure($sformatf("block left after %0d enabled edges, not %0d",
						enabled_edges - edge_q[0], PIPE_LATENCY));
				void'(tag_q.pop_front());
				void'(block_q.pop_front());
				void'(edge_q.pop_front());
				delivered++;
			end

			if (valid_in && ready_in) begin
				tag_q.push_back(tag_in);
				block_q.push_back(data_in);
				edge_q.push_back(enabled_edges);
				accepted++;
			end

			if (ready_in) begin
				enabled_edges++;
			end
			prev_stalled = !ready_in;
			prev_valid_out = valid_out;
			prev_tag_out = tag_out;
			prev_data_out = data_out;
		end
	end

	initial begin
		int sent;
		logic [31:0] bits;
		clk = 1'b0;
		reset = 1'b1;
		valid_in = 1'b0;
		ready_in = 1'b0;
		tag_in = '0;
		data_in = '0;
		lfsr_state = 32'h13837792;

		repeat (2) @(posedge clk);
		#(DRIVE_DELAY);
		reset = 1'b0;

		// idle state straight out of reset
		@(negedge clk);
		assert (valid_out == 1'b0)
			else report_mismatch("valid_out", $sformatf("%b", valid_out), "0");
		assert (busy == 1'b0)
			else report_mismatch("busy", $sformatf("%b", busy), "0");
		assert (data_out == '0)
			else report_mismatch("data_out", $sformatf("%h", data_out), "0");
		assert (tag_out == '0)
			else report_mismatch("tag_out", $sformatf("%h", tag_out), "0");

		// one lone block
		@(posedge clk);
		#(DRIVE_DELAY);
		ready_in = 1'b1;
		valid_in = 1'b1;
		random_block();
		@(posedge clk);
		#(DRIVE_DELAY);
		valid_in = 1'b0;
		wait_for_drain();

		// back to back, no stalls
		valid_in = 1'b1;
		for (int n = 0; n < BURST_BLOCKS; n++) begin
			random_block();
			@(posedge clk);
			#(DRIVE_DELAY);
		end
		valid_in = 1'b0;
		wait_for_drain();

		// random valid and ready patterns
		sent = 0;
		while (sent < STALL_BLOCKS) begin
			take_bits(2, bits);
			valid_in = |bits[1:0];
			take_bits(1, bits);
			ready_in = bits[0];
			if (valid_in) begin
				random_block();
			end
			@(posedge clk);
			if (valid_in && ready_in) begin
				sent++;
			end
			#(DRIVE_DELAY);
		end
		valid_in = 1'b0;
		ready_in = 1'b1;
		wait_for_drain();

		assert (accepted == PLANNED_BLOCKS)
			else report_failure($sformatf("%0d blocks accepted instead of %0d",
				accepted, PLANNED_BLOCKS));
		assert (delivered == PLANNED_BLOCKS)
			else report_failure($sformatf("%0d blocks delivered instead of %0d",
				delivered, PLANNED_BLOCKS));
		assert (busy == 1'b0)
			else report_mismatch("busy", $sformatf("%b", busy), "0");

		$display("TEST PASSED");
		$finish;
	end

	// generous bound on the whole run
	initial begin
		#(PLANNED_BLOCKS * CYCLES_PER_BLOCK * CLK_PERIOD);
		$display("ERROR at %0t: timeout, the run did not finish within %0d cycles", $time,
			PLANNED_BLOCKS * CYCLES_PER_BLOCK);
		$display("TEST FAILED");
		$fatal(1, "watchdog timeout");
	end

endmodule

`default_nettype wire

/* verification/prefix_adder_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

// control output checks on the adder top level
module prefix_adder_assertions (
	input wire logic clk,
	input wire logic reset,
	input wire logic ready_in,
	input wire logic busy,
	input wire logic valid_out,
	input wire prefix_ctrl_pkg::tag_t tag_out,
	input wire prefix_data_pkg::block_t data_out
);

	// reset empties the valid train
	reset_clears: assert property (@(posedge clk) reset |-> (!valid_out && !busy))
		else $error("valid_out or busy high during reset");

	// the valid train only empties on an enabled edge
	busy_falls_on_enable: assert property (@(posedge clk) disable iff (reset)
		$fell(busy) |-> $past(ready_in))
		else $error("busy fell across a stalled edge");

	// output stage frozen while downstream holds off
	hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		!ready_in |=> ($stable(valid_out) && $stable(tag_out) && $stable(data_out)))
		else $error("outputs changed across a stalled edge");

endmodule

bind prefix_adder_top prefix_adder_assertions u_assertions (
	.clk(clk),
	.reset(reset),
	.ready_in(ready_in),
	.busy(busy),
	.valid_out(valid_out),
	.tag_out(tag_out),
	.data_out(data_out)
);

`default_nettype wire

/* source/prefix_adder_top.sv */
`timescale 1ns/10ps
`default_nettype none

// eight lane pipelined prefix adder
module prefix_adder_top (
	input wire logic clk,
	input wire logic reset,
	input wire logic valid_in,
	input wire logic ready_in,
	input wire prefix_ctrl_pkg::tag_t tag_in,
	input wire prefix_data_pkg::block_t data_in,

	output logic busy,
	output logic ready_out,
	output logic valid_out,
	output prefix_ctrl_pkg::tag_t tag_out,
	output prefix_data_pkg::block_t data_out
);

	// shared stage advance for control and data
	logic enable;

	pipe_control u_control (
		.clk(clk),
		.reset(reset),
		.valid_in(valid_in),
		.ready_in(ready_in),
		.tag_in(tag_in),
		.enable(enable),
		.ready_out(ready_out),
		.busy(busy),
		.valid_out(valid_out),
		.tag_out(tag_out)
	);

	prefix_network u_network (
		.clk(clk),
		.reset(reset),
		.enable(enable),
		.data_in(data_in),
		.sums(data_out)
	);

endmodule

`default_nettype wire

/* source/prefix_network.sv */
`timescale 1ns/10ps
`default_nettype none

`include "prefix_cfg.svh"

// input capture followed by the chained adder layers
module prefix_network (
	input wire logic clk,
	input wire logic reset,
	input wire logic enable,
	input wire prefix_data_pkg::block_t data_in,

	output prefix_data_pkg::block_t sums
);

	prefix_data_pkg::block_t captured;

	// entry 0 is the captured block, entry n the output of layer n
	prefix_data_pkg::block_t layer_sums [0:`PREFIX_LAYERS];

	// capture stage
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			captured <= '0;
		end else if (enable) begin
			captured <= data_in;
		end
	end

	assign layer_sums[0] = captured;

	// spans of 1, 2 and 4 lanes
	for (genvar l = 0; l < `PREFIX_LAYERS; l++) begin : g_layer
		prefix_layer #(
			.SPAN(1 << l)
		) u_layer (
			.clk(clk),
			.reset(reset),
			.enable(enable),
			.sums_in(layer_sums[l]),
			.sums_out(layer_sums[l+1])
		);
	end

	// inclusive prefix sums after the last layer
	assign sums = layer_sums[`PREFIX_LAYERS];

endmodule

`default_nettype wire

/* source/prefix_layer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "prefix_cfg.svh"

// one registered layer of the Sklansky prefix tree
// SPAN must be a power of two below the lane count
module prefix_layer #(
	parameter int SPAN = 1
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic enable,
	input wire prefix_data_pkg::block_t sums_in,

	output prefix_data_pkg::block_t sums_out
);

	prefix_data_pkg::block_t next_sums;

	// lanes are grouped in runs of 2*SPAN
	// the upper half of each group adds the top lane of the lower half
	for (genvar i = 0; i < `PREFIX_LANES; i++) begin : g_lane
		if ((i & SPAN) != 0) begin : g_add
			localparam int SRC = (i / (2 * SPAN)) * (2 * SPAN) + SPAN - 1;

			// wraps at lane width, no overflow kept
			assign next_sums[i] = sums_in[i] + sums_in[SRC];
		end else begin : g_pass
			assign next_sums[i] = sums_in[i];
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sums_out <= '0;
		end else if (enable) begin
			sums_out <= next_sums;
		end
	end

endmodule

`default_nettype wire

/* source/pipe_control.sv */
`timescale 1ns/10ps
`default_nettype none

`include "prefix_cfg.svh"

// valid and tag train running beside the adder network
module pipe_control (
	input wire logic clk,
	input wire logic reset,
	input wire logic valid_in,
	input wire logic ready_in,
	input wire prefix_ctrl_pkg::tag_t tag_in,

	output logic enable,
	output logic ready_out,
	output logic busy,
	output logic valid_out,
	output prefix_ctrl_pkg::tag_t tag_out
);

	prefix_ctrl_pkg::stage_valid_t stage_valid;
	prefix_ctrl_pkg::tag_t tag_pipe [0:`PREFIX_STAGES-1];

	// the whole pipeline moves as one
	// a low ready_in freezes every stage, bubbles included
	assign enable = ready_in;
	assign ready_out = ready_in;

	// valid bits shift toward the output on each enabled edge
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			stage_valid <= '0;
		end else if (enable) begin
			stage_valid <= {stage_valid[`PREFIX_STAGES-2:0], valid_in};
		end
	end

	// tags follow the same path as the valid bits
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < `PREFIX_STAGES; s++) begin
				tag_pipe[s] <= '0;
			end
		end else if (enable) begin
			tag_pipe[0] <= tag_in;
			for (int s = 1; s < `PREFIX_STAGES; s++) begin
				tag_pipe[s] <= tag_pipe[s-1];
			end
		end
	end

	// anything still in flight
	assign busy = |stage_valid;

	// last stage lines up with the final adder layer
	assign valid_out = stage_valid[`PREFIX_STAGES-1];
	assign tag_out = tag_pipe[`PREFIX_STAGES-1];

endmodule

`default_nettype wire

/* source/prefix_ctrl_pkg.sv */
`default_nettype none

`include "prefix_cfg.svh"

package prefix_ctrl_pkg;

	typedef logic [`PREFIX_TAG_WIDTH-1:0] tag_t;

	// one valid bit per registered stage, stage 0 in bit 0
	typedef logic [`PREFIX_STAGES-1:0] stage_valid_t;

endpackage

`default_nettype wire

/* source/prefix_data_pkg.sv */
`default_nettype none

`include "prefix_cfg.svh"

package prefix_data_pkg;

	// one signed lane
	typedef logic signed [`PREFIX_LANE_WIDTH-1:0] lane_t;

	// a whole block of lanes
	// lane 0 sits in the low bits
	typedef lane_t [`PREFIX_LANES-1:0] block_t;

endpackage

`default_nettype wire

/* source/prefix_cfg.svh */
`ifndef PREFIX_CFG_SVH
`define PREFIX_CFG_SVH

// bits per lane, sums wrap at this width
`define PREFIX_LANE_WIDTH 8

// lanes per block
`define PREFIX_LANES 8

// tag carried beside each block
`define PREFIX_TAG_WIDTH 32

// log2 of the lane count, one adder layer per span
`define PREFIX_LAYERS 3

// capture register plus one register per layer
`define PREFIX_STAGES 4

`endif
